//--- atc_tower.f
+incdir+logic
logic/atc_pkg.sv
logic/atc_fifo.sv
logic/aircraft_id_pool.sv
logic/runway_tracker.sv
logic/request_controller.sv
logic/reply_sender.sv
logic/atc_tower.sv
sim/atc_tower_assertions.sv
sim/atc_tower_tb.sv

//--- Bender.yml
package:
  name: atc_tower

sources:
  - include_dirs:
      - logic
    files:
      - logic/atc_pkg.sv
      - logic/atc_fifo.sv
      - logic/aircraft_id_pool.sv
      - logic/runway_tracker.sv
      - logic/request_controller.sv
      - logic/reply_sender.sv
      - logic/atc_tower.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/atc_tower_assertions.sv
      - sim/atc_tower_tb.sv

//--- sim/atc_tower_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "atc_settings.svh"

module atc_tower_tb import atc_pkg::*; ();
	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int QUIET_WINDOW = 40; // cycles without a reply.
	localparam int DIRECTED_REQUESTS = 48; // upper bound.
	localparam int RANDOM_REQUESTS = 160;
	localparam int CYCLES_PER_REQUEST = 200;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES +
		(DIRECTED_REQUESTS + RANDOM_REQUESTS) * CYCLES_PER_REQUEST + 500;
	localparam int ID_COUNT = 2 ** `ATC_ID_BITS;

	logic clock;
	logic reset;
	atc_word_t request;
	logic request_valid;
	logic reply_credit;
	logic request_credit;
	atc_word_t reply;
	logic reply_valid;
	runway_mask_t runway_busy;

	// reference model state.
	id_mask_t model_taken;
	aircraft_id_t model_takeoff [$];
	aircraft_id_t model_landing [$];
	runway_mask_t model_busy;
	aircraft_id_t model_occupant [`ATC_RUNWAYS];
	logic model_prefer_landing;
	atc_word_t expected [$];

	string test_name = "reset";
	int mismatch_count = 0;
	int flow_errors = 0;
	int request_credits = `ATC_REQUEST_DEPTH;
	int requests_sent = 0;
	int credit_pulses = 0;
	int owed_credits = 0;
	int idle_cycles = 0;
	int max_credit_delay = 2;
	logic [31:0] stimulus_state;
	logic [31:0] credit_state;

	atc_tower UUT (
		.clock(clock),
		.reset(reset),
		.request(request),
		.request_valid(request_valid),
		.reply_credit(reply_credit),
		.request_credit(request_credit),
		.reply(reply),
		.reply_valid(reply_valid),
		.runway_busy(runway_busy)
	);

	initial begin : clock_gen
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int unsigned pick(input int unsigned bound);
		stimulus_state = xorshift(stimulus_state);
		return stimulus_state % bound;
	endfunction

	function automatic string describe(input atc_word_t w);
		return $sformatf("id %0d type %b action %b", w.id, w.msg_type, w.action);
	endfunction

	function automatic int lowest_free_runway();
		for (int r = 0; r < `ATC_RUNWAYS; r++) begin
			if (!model_busy[r])
				return r;
		end
		return -1;
	endfunction

	function automatic aircraft_id_t lowest_free_id();
		for (int i = 0; i < ID_COUNT; i++) begin
			if (!model_taken[i])
				return aircraft_id_t'(i);
		end
		return '0;
	endfunction

	function automatic logic is_queued(input aircraft_id_t id);
		foreach (model_takeoff[i])
			if (model_takeoff[i] == id)
				return 1'b1;
		foreach (model_landing[i])
			if (model_landing[i] == id)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic int runway_of(input aircraft_id_t id);
		for (int r = 0; r < `ATC_RUNWAYS; r++) begin
			if (model_busy[r] && model_occupant[r] == id)
				return r;
		end
		return -1;
	endfunction

	function automatic int assertion_failures();
		return UUT.sender.sender_checks.failures + UUT.runways.runway_checks.failures;
	endfunction

	// ====================
	// reference model
	// ====================
	function automatic void model_step(input atc_word_t req);
		atc_word_t rsp;
		int r;
		logic landing;
		aircraft_id_t cleared;
		rsp.id = req.id;
		rsp.msg_type = say_again;
		rsp.action = 2'b00;
		case (req.msg_type)
			plane_request: begin
				if (model_taken[req.id]) begin
					rsp.msg_type = hold;
					if (req.action[1]) begin
						if (model_landing.size() == `ATC_QUEUE_DEPTH)
							rsp.msg_type = divert;
						else
							model_landing.push_back(req.id);
					end else if (model_takeoff.size() == `ATC_QUEUE_DEPTH) begin
						rsp.msg_type = divert;
					end else begin
						model_takeoff.push_back(req.id);
					end
					expected.push_back(rsp);
				end
			end
			runway_release: begin
				if (model_taken[req.id]) begin
					model_taken[req.id] = 1'b0;
					r = req.action[0];
					if (model_busy[r] && model_occupant[r] == req.id)
						model_busy[r] = 1'b0; // only the occupant frees it.
				end
			end
			id_request: begin
				rsp.msg_type = id_request;
				if (&model_taken) begin
					rsp.id = '0;
					rsp.action = 2'b11;
				end else begin
					rsp.id = lowest_free_id();
					model_taken[rsp.id] = 1'b1;
				end
				expected.push_back(rsp);
			end
			default: expected.push_back(rsp);
		endcase
		// clear until runways or queues run out.
		r = lowest_free_runway();
		while (r >= 0 && (model_takeoff.size() > 0 || model_landing.size() > 0)) begin
			if (model_prefer_landing)
				landing = model_landing.size() > 0;
			else
				landing = model_takeoff.size() == 0;
			if (landing)
				cleared = model_landing.pop_front();
			else
				cleared = model_takeoff.pop_front();
			model_busy[r] = 1'b1;
			model_occupant[r] = cleared;
			rsp.id = cleared;
			rsp.msg_type = clear;
			rsp.action = {landing, runway_index_t'(r)};
			expected.push_back(rsp);
			model_prefer_landing = !model_prefer_landing;
			r = lowest_free_runway();
		end
	endfunction

	// ====================
	// monitor and credits
	// ====================
	always @(posedge clock) begin : compare_replies
		atc_word_t want;
		if (!reset) begin
			if (request_credit) begin
				request_credits++;
				credit_pulses++;
			end
			if (reply_valid) begin
				idle_cycles = 0;
				owed_credits++;
				assert (expected.size() > 0) else begin
					flow_errors++;
					$display("unexpected reply (%s) in test %s", describe(reply), test_name);
				end
				if (expected.size() > 0) begin
					want = expected.pop_front();
					assert (reply === want) else begin
						mismatch_count++;
						$display("MISMATCH %s expected %s actual %s", test_name,
							describe(want), describe(reply));
					end
				end
			end else begin
				idle_cycles++;
			end
		end
	end

	initial begin : return_credits
		int unsigned wait_cycles;
		reply_credit = 1'b0;
		wait_cycles = 0;
		forever begin
			@(negedge clock);
			reply_credit = 1'b0;
			if (!reset && owed_credits > 0) begin
				if (wait_cycles > 0) begin
					wait_cycles--;
				end else begin
					reply_credit = 1'b1;
					owed_credits--;
					credit_state = xorshift(credit_state);
					wait_cycles = credit_state % (max_credit_delay + 1);
				end
			end
		end
	end

	// ====================
	// stimulus
	// ====================
	task automatic wait_quiet();
		do
			@(negedge clock);
		while (idle_cycles < QUIET_WINDOW || owed_credits != 0 ||
			request_credits < `ATC_REQUEST_DEPTH);
		assert (expected.size() == 0) else begin
			flow_errors += expected.size();
			$display("%0d expected replies never arrived in test %s", expected.size(),
				test_name);
			expected.delete();
		end
		assert (runway_busy === model_busy) else begin
			mismatch_count++;
			$display("MISMATCH %s runway_busy expected %b actual %b", test_name,
				model_busy, runway_busy);
		end
	endtask

	task automatic issue_request(input aircraft_id_t id, input logic [2:0] kind,
		input logic [1:0] action);
		atc_word_t word;
		word.id = id;
		word.msg_type = msg_type_t'(kind);
		word.action = action;
		while (request_credits == 0)
			@(negedge clock);
		request = word;
		request_valid = 1'b1;
		request_credits--;
		requests_sent++;
		idle_cycles = 0;
		model_step(word);
		@(negedge clock);
		request_valid = 1'b0;
		wait_quiet();
	endtask

	// busy aircraft never request again and queued ones never release.
	task automatic random_request();
		aircraft_id_t id;
		int unsigned kind;
		int r;
		id = aircraft_id_t'(pick(ID_COUNT));
		kind = pick(8);
		r = runway_of(id);
		if (kind < 2) begin
			issue_request(id, id_request, 2'b00);
		end else if (kind < 5) begin
			if (is_queued(id) || r >= 0)
				issue_request(id, id_request, 2'b00);
			else
				issue_request(id, plane_request, {1'(pick(2)), 1'b0});
		end else if (kind < 7) begin
			if (is_queued(id))
				issue_request(id, 3'b010, 2'b00);
			else if (r >= 0)
				issue_request(id, runway_release, {1'b0, 1'(r)});
			else
				issue_request(id, runway_release, {1'b0, 1'(pick(2))});
		end else begin
			issue_request(id, 3'(2 + pick(5)), 2'b00); // unknown types.
		end
	endtask

	task automatic report_counts();
		$display("errors: %0d mismatches, %0d missing or unexpected, %0d assertion failures",
			mismatch_count, flow_errors, assertion_failures());
	endtask

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("timeout: the DUT stopped answering in test %s", test_name);
		report_counts();
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : run_tests
		reset = 1'b1;
		request = '0;
		request_valid = 1'b0;
		model_taken = '0;
		model_busy = '0;
		model_prefer_landing = 1'b0;
		stimulus_state = 32'd39;
		credit_state = xorshift(32'd39);
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;

		test_name = "id_allocation";
		for (int i = 0; i <= ID_COUNT; i++)
			issue_request(4'd0, id_request, 2'b00); // last one finds the pool empty.
		issue_request(4'd5, runway_release, 2'b00);
		issue_request(4'd0, id_request, 2'b00);

		test_name = "takeoff_landing";
		issue_request(4'd9, runway_release, 2'b00);
		issue_request(4'd9, plane_request, 2'b00); // untaken id.
		for (int i = 0; i <= 6; i++)
			issue_request(aircraft_id_t'(i), plane_request, 2'b00);
		issue_request(4'd7, plane_request, 2'b10);
		issue_request(4'd8, plane_request, 2'b10);

		test_name = "runway_release";
		issue_request(4'd0, runway_release, 2'b00);
		issue_request(4'd1, runway_release, 2'b01);
		issue_request(4'd2, runway_release, 2'b00);
		issue_request(4'd7, runway_release, 2'b01);
		issue_request(4'd6, runway_release, 2'b00); // not the occupant.
		issue_request(4'd3, runway_release, 2'b00);
		issue_request(4'd8, runway_release, 2'b01);
		issue_request(4'd4, runway_release, 2'b00);
		issue_request(4'd5, runway_release, 2'b01);

		test_name = "unknown_types";
		for (int k = 2; k <= 6; k++)
			issue_request(aircraft_id_t'(k + 8), 3'(k), 2'b01);

		test_name = "back_pressure";
		max_credit_delay = 12;
		repeat (RANDOM_REQUESTS) random_request();

		assert (credit_pulses == requests_sent) else begin
			flow_errors++;
			$display("request_credit pulsed %0d times for %0d requests", credit_pulses,
				requests_sent);
		end
		report_counts();
		if (mismatch_count == 0 && flow_errors == 0 && assertion_failures() == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/atc_tower_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "atc_settings.svh"

module atc_tower_assertions import atc_pkg::*; #(
	parameter bit CHECK_CREDITS = 1'b1,
	parameter bit CHECK_RUNWAYS = 1'b1
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic reply_valid,
	input wire logic [$clog2(`ATC_REPLY_CREDITS + 1)-1:0] credits,
	input wire runway_mask_t runway_busy,
	input wire aircraft_id_t occupant [`ATC_RUNWAYS]
);
	int failures = 0;

	// ====================
	// reply credits
	// ====================
	if (CHECK_CREDITS) begin : credit_checks
		valid_needs_credit: assert property (
			@(posedge clock) disable iff (reset) reply_valid |-> credits != '0
		) else begin
			failures++;
			$error("reply_valid raised while the sender held no reply credit");
		end

		credit_bound: assert property (
			@(posedge clock) disable iff (reset) credits <= `ATC_REPLY_CREDITS
		) else begin
			failures++;
			$error("reply credit count above the receiver buffer size");
		end
	end

	// ====================
	// runways
	// ====================
	if (CHECK_RUNWAYS) begin : runway_state_checks
		logic shared_occupant;

		// any pair of busy runways with one id.
		always_comb begin
			shared_occupant = 1'b0;
			for (int a = 0; a < `ATC_RUNWAYS; a++) begin
				for (int b = a + 1; b < `ATC_RUNWAYS; b++) begin
					if (runway_busy[a] && runway_busy[b] && occupant[a] == occupant[b])
						shared_occupant = 1'b1;
				end
			end
		end

		unique_occupants: assert property (
			@(posedge clock) disable iff (reset) !shared_occupant
		) else begin
			failures++;
			$error("one aircraft holds two busy runways");
		end
	end

endmodule

bind reply_sender atc_tower_assertions #(
	.CHECK_CREDITS(1'b1),
	.CHECK_RUNWAYS(1'b0)
) sender_checks (
	.clock(clock),
	.reset(reset),
	.reply_valid(reply_valid),
	.credits(credits),
	.runway_busy('0),
	.occupant()
);

bind runway_tracker atc_tower_assertions #(
	.CHECK_CREDITS(1'b0),
	.CHECK_RUNWAYS(1'b1)
) runway_checks (
	.clock(clock),
	.reset(reset),
	.reply_valid(1'b0),
	.credits('0),
	.runway_busy(runway_busy),
	.occupant(occupant)
);

`default_nettype wire

//--- logic/atc_tower.sv
`timescale 1ns/1ns
`default_nettype none

`include "atc_settings.svh"

module atc_tower import atc_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire atc_word_t request,
	input wire logic request_valid,
	input wire logic reply_credit,
	output logic request_credit,
	output atc_word_t reply,
	output logic reply_valid,
	output runway_mask_t runway_busy
);
	atc_word_t request_word;
	logic request_empty;
	aircraft_id_t queue_id;
	aircraft_id_t takeoff_head;
	aircraft_id_t landing_head;
	logic takeoff_full;
	logic takeoff_empty;
	logic takeoff_push;
	logic takeoff_pop;
	logic landing_full;
	logic landing_empty;
	logic landing_push;
	logic landing_pop;
	id_mask_t id_taken;
	aircraft_id_t free_id;
	logic ids_exhausted;
	logic id_take;
	logic id_release;
	logic lock;
	logic unlock;
	runway_index_t runway;
	aircraft_id_t lock_id;
	atc_word_t reply_word;
	logic reply_push;
	logic reply_full;

	// ====================
	// buffers
	// ====================
	// credits keep this FIFO from overflowing.
	atc_fifo #(
		.WIDTH($bits(atc_word_t)),
		.DEPTH(`ATC_REQUEST_DEPTH)
	) requests (
		.clock(clock),
		.reset(reset),
		.data_in(request),
		.push(request_valid),
		.pop(request_credit),
		.data_out(request_word),
		.full(),
		.empty(request_empty)
	);

	atc_fifo #(
		.WIDTH($bits(aircraft_id_t)),
		.DEPTH(`ATC_QUEUE_DEPTH)
	) takeoff_queue (
		.clock(clock),
		.reset(reset),
		.data_in(queue_id),
		.push(takeoff_push),
		.pop(takeoff_pop),
		.data_out(takeoff_head),
		.full(takeoff_full),
		.empty(takeoff_empty)
	);

	atc_fifo #(
		.WIDTH($bits(aircraft_id_t)),
		.DEPTH(`ATC_QUEUE_DEPTH)
	) landing_queue (
		.clock(clock),
		.reset(reset),
		.data_in(queue_id),
		.push(landing_push),
		.pop(landing_pop),
		.data_out(landing_head),
		.full(landing_full),
		.empty(landing_empty)
	);

	// ====================
	// control
	// ====================
	aircraft_id_pool id_pool (
		.clock(clock),
		.reset(reset),
		.take(id_take),
		.give_back(id_release),
		.release_id(request_word.id),
		.free_id(free_id),
		.taken(id_taken),
		.exhausted(ids_exhausted)
	);

	runway_tracker runways (
		.clock(clock),
		.reset(reset),
		.lock(lock),
		.unlock(unlock),
		.runway(runway),
		.lock_id(lock_id),
		.unlock_id(request_word.id), // the releasing aircraft.
		.runway_busy(runway_busy)
	);

	request_controller controller (
		.clock(clock),
		.reset(reset),
		.request(request_word),
		.request_empty(request_empty),
		.request_pop(request_credit),
		.takeoff_head(takeoff_head),
		.landing_head(landing_head),
		.takeoff_full(takeoff_full),
		.takeoff_empty(takeoff_empty),
		.landing_full(landing_full),
		.landing_empty(landing_empty),
		.takeoff_push(takeoff_push),
		.landing_push(landing_push),
		.takeoff_pop(takeoff_pop),
		.landing_pop(landing_pop),
		.queue_id(queue_id),
		.id_taken(id_taken),
		.free_id(free_id),
		.ids_exhausted(ids_exhausted),
		.id_take(id_take),
		.id_release(id_release),
		.runway_busy(runway_busy),
		.lock(lock),
		.unlock(unlock),
		.runway(runway),
		.lock_id(lock_id),
		.reply_word(reply_word),
		.reply_push(reply_push),
		.reply_full(reply_full)
	);

	reply_sender sender (
		.clock(clock),
		.reset(reset),
		.reply_word(reply_word),
		.reply_push(reply_push),
		.reply_full(reply_full),
		.reply_credit(reply_credit),
		.reply(reply),
		.reply_valid(reply_valid)
	);

endmodule

`default_nettype wire

//--- logic/reply_sender.sv
`timescale 1ns/1ns
`default_nettype none

`include "atc_settings.svh"

module reply_sender import atc_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire atc_word_t reply_word,
	input wire logic reply_push,
	output logic reply_full,
	input wire logic reply_credit,
	output atc_word_t reply,
	output logic reply_valid
);
	localparam int CREDIT_BITS = $clog2(`ATC_REPLY_CREDITS + 1);

	logic [CREDIT_BITS-1:0] credits;
	logic fifo_empty;
	logic send_pop;

	// keep one credit back for the word already in flight.
	assign send_pop = !fifo_empty && (credits != '0) &&
		!(reply_valid && credits == CREDIT_BITS'(1));

	// data_out is the output register.
	atc_fifo #(
		.WIDTH($bits(atc_word_t)),
		.DEPTH(`ATC_REPLY_DEPTH)
	) replies (
		.clock(clock),
		.reset(reset),
		.data_in(reply_word),
		.push(reply_push),
		.pop(send_pop),
		.data_out(reply),
		.full(reply_full),
		.empty(fifo_empty)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= CREDIT_BITS'(`ATC_REPLY_CREDITS);
			reply_valid <= 1'b0;
		end else begin
			reply_valid <= send_pop;
			if (reply_credit && !reply_valid)
				credits <= credits + 1'b1;
			else if (reply_valid && !reply_credit)
				credits <= credits - 1'b1; // spent on the pulse.
		end
	end

endmodule

`default_nettype wire

//--- logic/request_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "atc_settings.svh"

module request_controller import atc_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire atc_word_t request,
	input wire logic request_empty,
	output logic request_pop,
	input wire aircraft_id_t takeoff_head,
	input wire aircraft_id_t landing_head,
	input wire logic takeoff_full,
	input wire logic takeoff_empty,
	input wire logic landing_full,
	input wire logic landing_empty,
	output logic takeoff_push,
	output logic landing_push,
	output logic takeoff_pop,
	output logic landing_pop,
	output aircraft_id_t queue_id,
	input wire id_mask_t id_taken,
	input wire aircraft_id_t free_id,
	input wire logic ids_exhausted,
	output logic id_take,
	output logic id_release,
	input wire runway_mask_t runway_busy,
	output logic lock,
	output logic unlock,
	output runway_index_t runway,
	output aircraft_id_t lock_id,
	output atc_word_t reply_word,
	output logic reply_push,
	input wire logic reply_full
);
	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_decode,
		st_reply,
		st_clear_select,
		st_clear_lock,
		st_clear_reply
	} state_t;

	state_t state;
	state_t next_state;
	atc_word_t next_reply;
	logic load_reply;
	logic prefer_landing; // flips after every clearance.
	logic clearing_landing;
	logic pick_landing;
	logic runway_free;
	logic any_waiting;
	runway_index_t lowest_free;

	assign queue_id = request.id;
	assign lock_id = clearing_landing ? landing_head : takeoff_head;
	assign runway_free = ~&runway_busy;
	assign any_waiting = !takeoff_empty || !landing_empty;
	assign pick_landing = !landing_empty && (takeoff_empty || prefer_landing);

	always_comb begin
		lowest_free = '0;
		for (int r = `ATC_RUNWAYS - 1; r >= 0; r--) begin
			if (!runway_busy[r])
				lowest_free = runway_index_t'(r);
		end
	end

	// ====================
	// next state
	// ====================
	always_comb begin
		next_state = state;
		request_pop = 1'b0;
		takeoff_push = 1'b0;
		landing_push = 1'b0;
		takeoff_pop = 1'b0;
		landing_pop = 1'b0;
		id_take = 1'b0;
		id_release = 1'b0;
		lock = 1'b0;
		unlock = 1'b0;
		runway = lowest_free;
		reply_push = 1'b0;
		load_reply = 1'b0;
		next_reply = '0;
		case (state)
			st_idle: next_state = request_empty ? st_clear_select : st_read;
			st_read: begin
				request_pop = 1'b1;
				next_state = st_decode;
			end
			st_decode: begin
				next_state = st_clear_select; // silent unless a reply is built.
				next_reply.id = request.id;
				next_reply.action = action_none;
				case (request.msg_type)
					plane_request: begin
						if (id_taken[request.id]) begin
							load_reply = 1'b1;
							next_state = st_reply;
							next_reply.msg_type = hold;
							if (request.action[1]) begin
								if (landing_full)
									next_reply.msg_type = divert;
								else
									landing_push = 1'b1;
							end else if (takeoff_full) begin
								next_reply.msg_type = divert;
							end else begin
								takeoff_push = 1'b1;
							end
						end
					end
					runway_release: begin
						if (id_taken[request.id]) begin
							id_release = 1'b1;
							unlock = 1'b1;
							runway = runway_index_t'(request.action[0]);
						end
					end
					id_request: begin
						load_reply = 1'b1;
						next_state = st_reply;
						next_reply.msg_type = id_request;
						if (ids_exhausted) begin
							next_reply.id = '0;
							next_reply.action = action_no_id;
						end else begin
							next_reply.id = free_id;
							id_take = 1'b1;
						end
					end
					default: begin
						load_reply = 1'b1;
						next_state = st_reply;
						next_reply.msg_type = say_again;
					end
				endcase
			end
			st_reply: begin
				if (!reply_full) begin
					reply_push = 1'b1;
					next_state = st_clear_select;
				end
			end
			st_clear_select: begin
				if (runway_free && any_waiting) begin
					takeoff_pop = !pick_landing;
					landing_pop = pick_landing;
					next_state = st_clear_lock;
				end else begin
					next_state = st_idle;
				end
			end
			st_clear_lock: begin
				lock = 1'b1; // queue head is valid now.
				load_reply = 1'b1;
				next_reply.id = lock_id;
				next_reply.msg_type = clear;
				next_reply.action = {clearing_landing, lowest_free};
				next_state = st_clear_reply;
			end
			st_clear_reply: begin
				if (!reply_full) begin
					reply_push = 1'b1;
					next_state = st_idle;
				end
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			prefer_landing <= 1'b0; // takeoff first.
			clearing_landing <= 1'b0;
		end else begin
			state <= next_state;
			if (takeoff_pop || landing_pop)
				clearing_landing <= landing_pop;
			if (state == st_clear_lock)
				prefer_landing <= !prefer_landing;
		end
	end

	always_ff @(posedge clock) begin
		if (load_reply)
			reply_word <= next_reply;
	end

endmodule

`default_nettype wire

//--- logic/runway_tracker.sv
`timescale 1ns/1ns
`default_nettype none

`include "atc_settings.svh"

module runway_tracker import atc_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic lock,
	input wire logic unlock,
	input wire runway_index_t runway,
	input wire aircraft_id_t lock_id,
	input wire aircraft_id_t unlock_id,
	output runway_mask_t runway_busy
);
	aircraft_id_t occupant [`ATC_RUNWAYS];
	logic holder_match;

	// only the aircraft on the runway may free it.
	assign holder_match = (unlock_id == occupant[runway]);

	// ====================
	// occupant ids
	// ====================
	always_ff @(posedge clock) begin
		if (lock)
			occupant[runway] <= lock_id;
	end

	// ====================
	// busy flags
	// ====================
	always_ff @(posedge clock) begin
		if (reset) begin
			runway_busy <= '0;
		end else if (lock) begin
			runway_busy[runway] <= 1'b1;
		end else if (unlock && holder_match) begin
			runway_busy[runway] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/aircraft_id_pool.sv
`timescale 1ns/1ns
`default_nettype none

`include "atc_settings.svh"

module aircraft_id_pool import atc_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic take,
	input wire logic give_back,
	input wire aircraft_id_t release_id,
	output aircraft_id_t free_id,
	output id_mask_t taken,
	output logic exhausted
);
	localparam int ID_COUNT = 2 ** `ATC_ID_BITS;

	assign exhausted = &taken;

	// lowest free id wins.
	always_comb begin
		free_id = '0;
		for (int i = ID_COUNT - 1; i >= 0; i--) begin
			if (!taken[i])
				free_id = aircraft_id_t'(i);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			taken <= '0;
		end else if (give_back) begin
			taken[release_id] <= 1'b0; // release beats take.
		end else if (take && !exhausted) begin
			taken[free_id] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/atc_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module atc_fifo #(
	parameter int WIDTH = 9,
	parameter int DEPTH = 4
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [WIDTH-1:0] data_in,
	input wire logic push,
	input wire logic pop,
	output logic [WIDTH-1:0] data_out,
	output logic full,
	output logic empty
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_BITS-1:0] put_ptr;
	logic [PTR_BITS-1:0] get_ptr;
	logic [PTR_BITS:0] count;
	logic do_push;
	logic do_pop;

	// wraps for depths that are not a power of two.
	function automatic logic [PTR_BITS-1:0] advance(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == (PTR_BITS + 1)'(DEPTH));
	assign do_pop = pop && !empty;
	assign do_push = push && (!full || do_pop); // full still takes a word when one leaves.

	always_ff @(posedge clock) begin
		if (reset) begin
			put_ptr <= '0;
			get_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				put_ptr <= advance(put_ptr);
			if (do_pop)
				get_ptr <= advance(get_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			storage[put_ptr] <= data_in;
		if (do_pop)
			data_out <= storage[get_ptr]; // valid the cycle after pop.
	end

endmodule

`default_nettype wire

//--- logic/atc_pkg.sv
`default_nettype none

`include "atc_settings.svh"

package atc_pkg;

	typedef logic [`ATC_ID_BITS-1:0] aircraft_id_t;
	typedef logic [2**`ATC_ID_BITS-1:0] id_mask_t; // one bit per id.

	typedef logic [`ATC_RUNWAYS-1:0] runway_mask_t;
	typedef logic [$clog2(`ATC_RUNWAYS)-1:0] runway_index_t;

	// emergency 010 is no longer decoded.
	typedef enum logic [2:0] {
		plane_request  = 3'b000, // action[1] set for landing.
		runway_release = 3'b001, // action[0] selects the runway.
		clear          = 3'b011,
		hold           = 3'b100,
		say_again      = 3'b101,
		divert         = 3'b110,
		id_request     = 3'b111
	} msg_type_t;

	typedef struct packed {
		aircraft_id_t id;
		msg_type_t msg_type;
		logic [1:0] action;
	} atc_word_t;

	// ====================
	// reply actions
	// ====================
	localparam logic [1:0] action_none = 2'b00;
	localparam logic [1:0] action_no_id = 2'b11; // id pool exhausted.

endpackage

`default_nettype wire

//--- logic/atc_settings.svh
`ifndef ATC_SETTINGS_SVH
`define ATC_SETTINGS_SVH

// ====================
// word layout
// ====================
`define ATC_ID_BITS 4

// ====================
// runways and buffering
// ====================
`define ATC_RUNWAYS 2

// request FIFO depth and the request credits held after reset.
`define ATC_REQUEST_DEPTH 4

`define ATC_QUEUE_DEPTH 4 // per direction.
`define ATC_REPLY_DEPTH 4

// one credit per receiver buffer slot.
`define ATC_REPLY_CREDITS 2

`endif
